/* include/video_defs.svh */
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Default active frame size of a 720p stream.
`define VIDEO_H_ACT 1280
`define VIDEO_V_ACT 720

// Cycles from an input pixel to its blurred output.
// Buffer 1, window 1, filter 2.
`define VIDEO_LATENCY 4

`endif

/* verilog/video_pkg.sv */
package video_pkg;

    // One pixel, red in the top byte.
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // Video sync as delivered with each pixel.
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } sync_t;

endpackage : video_pkg

/* verilog/line_ram.sv */
`include "video_defs.svh"

module line_ram #(
    parameter type word_t = logic [23:0],
    parameter      DEPTH  = `VIDEO_H_ACT
) (
    input                              clk,
    input        [$clog2(DEPTH)-1:0]   addr,
    input                              wr_en,
    input  word_t                      wr_data,
    output word_t                      rd_data
);

    word_t mem [DEPTH];

    // Read sees the old word, so a line is read and overwritten in one pass.
    always_ff @(posedge clk) begin
        rd_data <= mem[addr];
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

endmodule : line_ram

/* verilog/pipe_delay.sv */
module pipe_delay #(
    parameter type data_t = logic,
    parameter      DEPTH  = 1
) (
    input               clk,
    input               reset,
    input  data_t       din,
    output data_t       dout
);

    data_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[DEPTH-1];

endmodule : pipe_delay

/* verilog/three_line_buffer.sv */
`include "video_defs.svh"

module three_line_buffer import video_pkg::*; #(
    parameter H_ACT = `VIDEO_H_ACT
) (
    input              clk,
    input              reset,
    input              de,
    input              vsync,
    input  rgb_t       pix_in,
    output rgb_t       cur,
    output rgb_t       line1,
    output rgb_t       line2,
    output logic       buf_de
);

    localparam AW = $clog2(H_ACT);

    logic [AW-1:0] col;
    logic [1:0]    wsel;   // RAM being written, 0 = A.
    logic          wen_a;
    logic          wen_b;
    logic          wen_c;
    rgb_t          rdata_a;
    rgb_t          rdata_b;
    rgb_t          rdata_c;

    always_ff @(posedge clk) begin
        if (reset || vsync) begin
            col  <= '0;
            wsel <= 2'd0;
        end else begin
            col <= de ? col + AW'(1) : '0;
            if (buf_de && !de) begin // End of an active line.
                wsel <= (wsel == 2'd2) ? 2'd0 : wsel + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            buf_de <= 1'b0;
        end else begin
            buf_de <= de;
        end
    end

    line_ram #(.word_t(rgb_t), .DEPTH(H_ACT)) line_a_i (
        .clk     (clk),
        .addr    (col),
        .wr_en   (wen_a & de),
        .wr_data (pix_in),
        .rd_data (rdata_a)
    );

    line_ram #(.word_t(rgb_t), .DEPTH(H_ACT)) line_b_i (
        .clk     (clk),
        .addr    (col),
        .wr_en   (wen_b & de),
        .wr_data (pix_in),
        .rd_data (rdata_b)
    );

    line_ram #(.word_t(rgb_t), .DEPTH(H_ACT)) line_c_i (
        .clk     (clk),
        .addr    (col),
        .wr_en   (wen_c & de),
        .wr_data (pix_in),
        .rd_data (rdata_c)
    );

    // Matches the one-cycle RAM read.
    pipe_delay #(.data_t(rgb_t), .DEPTH(1)) cur_delay_i (
        .clk   (clk),
        .reset (reset),
        .din   (pix_in),
        .dout  (cur)
    );

    // Oldest unwritten RAM goes to line1.
    always_comb begin
        wen_a = 1'b0;
        wen_b = 1'b0;
        wen_c = 1'b0;
        case (wsel)
            2'd0: begin
                wen_a = 1'b1;
                line1 = rdata_b;
                line2 = rdata_c;
            end
            2'd1: begin
                wen_b = 1'b1;
                line1 = rdata_c;
                line2 = rdata_a;
            end
            2'd2: begin
                wen_c = 1'b1;
                line1 = rdata_a;
                line2 = rdata_b;
            end
            default: begin // Unreachable select.
                line1 = '0;
                line2 = '0;
            end
        endcase
    end

endmodule : three_line_buffer

/* verilog/window_3x3.sv */
module window_3x3 import video_pkg::*; (
    input              clk,
    input              reset,
    input              vsync_d,
    input              buf_de,
    input  rgb_t       cur,
    input  rgb_t       line1,
    input  rgb_t       line2,
    output rgb_t       tap_00,
    output rgb_t       tap_01,
    output rgb_t       tap_02,
    output rgb_t       tap_10,
    output rgb_t       tap_11,
    output rgb_t       tap_12,
    output rgb_t       tap_20,
    output rgb_t       tap_21,
    output rgb_t       tap_22,
    output logic       win_de,
    output logic       win_inside
);

    // Both counts saturate at 2, enough to tell the frame border.
    logic [1:0] col_cnt;
    logic [1:0] row_cnt;

    // Column 2 is the newest pixel, row 2 the current line.
    always_ff @(posedge clk) begin
        if (buf_de) begin
            tap_02 <= line1;
            tap_01 <= tap_02;
            tap_00 <= tap_01;
            tap_12 <= line2;
            tap_11 <= tap_12;
            tap_10 <= tap_11;
            tap_22 <= cur;
            tap_21 <= tap_22;
            tap_20 <= tap_21;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            col_cnt <= 2'd0;
        end else if (!buf_de) begin
            col_cnt <= 2'd0;
        end else if (col_cnt != 2'd2) begin
            col_cnt <= col_cnt + 2'd1;
        end
    end

    // win_de doubles as the previous buf_de for edge detection.
    always_ff @(posedge clk) begin
        if (reset || vsync_d) begin
            row_cnt <= 2'd0;
        end else if (win_de && !buf_de && row_cnt != 2'd2) begin
            row_cnt <= row_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            win_de     <= 1'b0;
            win_inside <= 1'b0;
        end else begin
            win_de     <= buf_de;
            win_inside <= buf_de && (col_cnt == 2'd2) && (row_cnt == 2'd2);
        end
    end

endmodule : window_3x3

/* verilog/gauss_blur.sv */
module gauss_blur import video_pkg::*; (
    input              clk,
    input              reset,
    input  rgb_t       tap_00,
    input  rgb_t       tap_01,
    input  rgb_t       tap_02,
    input  rgb_t       tap_10,
    input  rgb_t       tap_11,
    input  rgb_t       tap_12,
    input  rgb_t       tap_20,
    input  rgb_t       tap_21,
    input  rgb_t       tap_22,
    input              win_de,
    input              win_inside,
    output rgb_t       pix_out
);

    logic [9:0]  sum_top [3];   // Per channel, index 2 is red.
    logic [9:0]  sum_mid [3];
    logic [9:0]  sum_bot [3];
    logic [11:0] acc     [3];
    logic        valid;
    rgb_t        blur;

    // 1-2-1 weighting along one row.
    function automatic logic [9:0] row_sum(input logic [7:0] a, b, c);
        row_sum = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c};
    endfunction

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < 3; ch++) begin
            sum_top[ch] <= row_sum(tap_00[ch*8 +: 8], tap_01[ch*8 +: 8], tap_02[ch*8 +: 8]);
            sum_mid[ch] <= row_sum(tap_10[ch*8 +: 8], tap_11[ch*8 +: 8], tap_12[ch*8 +: 8]);
            sum_bot[ch] <= row_sum(tap_20[ch*8 +: 8], tap_21[ch*8 +: 8], tap_22[ch*8 +: 8]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else begin
            valid <= win_de && win_inside;
        end
    end

    // Middle row counts twice, +8 rounds the divide by 16.
    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            acc[ch] = {2'b00, sum_top[ch]} + {1'b0, sum_mid[ch], 1'b0}
                    + {2'b00, sum_bot[ch]} + 12'd8;
            blur[ch*8 +: 8] = acc[ch][11:4];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_out <= '0;
        end else begin
            pix_out <= valid ? blur : '0; // Black on the border.
        end
    end

endmodule : gauss_blur

/* verilog/video_blur_top.sv */
`include "video_defs.svh"

module video_blur_top import video_pkg::*; #(
    parameter H_ACT = `VIDEO_H_ACT,
    parameter V_ACT = `VIDEO_V_ACT
) (
    input              clk,
    input              reset,
    input              hsync,
    input              vsync,
    input              de,
    input  rgb_t       pix_in,
    output logic       out_hsync,
    output logic       out_vsync,
    output logic       out_de,
    output rgb_t       pix_out
);

    sync_t sync_in;
    sync_t sync_d1;
    sync_t sync_out;
    rgb_t  cur;
    rgb_t  line1;
    rgb_t  line2;
    logic  buf_de;
    rgb_t  tap_00, tap_01, tap_02;
    rgb_t  tap_10, tap_11, tap_12;
    rgb_t  tap_20, tap_21, tap_22;
    logic  win_de;
    logic  win_inside;

    // A 3x3 window needs at least three lines and columns.
    if (H_ACT < 3 || V_ACT < 3) begin : g_size_check
        $error("Frame too small for a 3x3 window");
    end

    assign sync_in   = '{hsync: hsync, vsync: vsync, de: de};
    assign out_hsync = sync_out.hsync;
    assign out_vsync = sync_out.vsync;
    assign out_de    = sync_out.de;

    three_line_buffer #(.H_ACT(H_ACT)) three_line_buffer_i (
        .clk    (clk),
        .reset  (reset),
        .de     (de),
        .vsync  (vsync),
        .pix_in (pix_in),
        .cur    (cur),
        .line1  (line1),
        .line2  (line2),
        .buf_de (buf_de)
    );

    // vsync in step with the buffer outputs.
    pipe_delay #(.data_t(sync_t), .DEPTH(1)) sync_d1_i (
        .clk   (clk),
        .reset (reset),
        .din   (sync_in),
        .dout  (sync_d1)
    );

    window_3x3 window_3x3_i (
        .clk        (clk),
        .reset      (reset),
        .vsync_d    (sync_d1.vsync),
        .buf_de     (buf_de),
        .cur        (cur),
        .line1      (line1),
        .line2      (line2),
        .tap_00     (tap_00),
        .tap_01     (tap_01),
        .tap_02     (tap_02),
        .tap_10     (tap_10),
        .tap_11     (tap_11),
        .tap_12     (tap_12),
        .tap_20     (tap_20),
        .tap_21     (tap_21),
        .tap_22     (tap_22),
        .win_de     (win_de),
        .win_inside (win_inside)
    );

    gauss_blur gauss_blur_i (
        .clk        (clk),
        .reset      (reset),
        .tap_00     (tap_00),
        .tap_01     (tap_01),
        .tap_02     (tap_02),
        .tap_10     (tap_10),
        .tap_11     (tap_11),
        .tap_12     (tap_12),
        .tap_20     (tap_20),
        .tap_21     (tap_21),
        .tap_22     (tap_22),
        .win_de     (win_de),
        .win_inside (win_inside),
        .pix_out    (pix_out)
    );

    pipe_delay #(.data_t(sync_t), .DEPTH(`VIDEO_LATENCY)) sync_delay_i (
        .clk   (clk),
        .reset (reset),
        .din   (sync_in),
        .dout  (sync_out)
    );

endmodule : video_blur_top

/* bench/tb_video_blur.sv */
`include "video_defs.svh"

module tb_video_blur import video_pkg::*; ();

    localparam int H            = 16;
    localparam int V            = 8;
    localparam int H_BLANK      = 4;
    localparam int V_BLANK      = 2;
    localparam int LAT          = `VIDEO_LATENCY;
    localparam int RESET_CYCLES = 3;
    localparam int N_FRAMES     = 3;
    localparam int FRAME_CYCLES = (V + V_BLANK) * (H + H_BLANK);
    localparam int MAX_CYCLES   = 2 * N_FRAMES * FRAME_CYCLES;
    localparam logic [31:0] SEED = 32'hdb5c;

    // Expected output of one input cycle, tagged with its test.
    typedef struct packed {
        sync_t      sync;
        rgb_t       pix;
        logic [1:0] test;
    } expect_t;

    logic    clk = 1'b0;
    logic    reset;
    logic    hsync;
    logic    vsync;
    logic    de;
    rgb_t    pix_in;
    logic    out_hsync;
    logic    out_vsync;
    logic    out_de;
    rgb_t    pix_out;

    rgb_t       frame [V][H];        // Current input frame.
    expect_t    exp_in;              // Set with each driven input.
    expect_t    exp_q [LAT];
    expect_t    expd;                // Due at the outputs now.
    logic       rst_q;
    logic       rst_q2;
    logic       in_reset;
    logic [1:0] last_test = 2'd0;
    int         checks [4] = '{default: 0};
    int         fails [4]  = '{default: 0};
    int         cycles     = 0;

    video_blur_top #(.H_ACT(H), .V_ACT(V)) video_blur_top_i (
        .clk       (clk),
        .reset     (reset),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .pix_in    (pix_in),
        .out_hsync (out_hsync),
        .out_vsync (out_vsync),
        .out_de    (out_de),
        .pix_out   (pix_out)
    );

    always #2 clk = ~clk;

    // Expectations travel the same number of cycles as the pixels.
    always @(posedge clk) begin
        rst_q  <= reset;
        rst_q2 <= rst_q;
        if (reset) begin
            for (int i = 0; i < LAT; i++) begin
                exp_q[i] <= '0;
            end
        end else begin
            exp_q[0] <= exp_in;
            for (int i = 1; i < LAT; i++) begin
                exp_q[i] <= exp_q[i-1];
            end
        end
    end

    assign expd     = exp_q[LAT-1];
    assign in_reset = rst_q || rst_q2;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic string test_name(input logic [1:0] t);
        case (t)
            2'd0:    return "reset state";
            2'd1:    return "random frame, border and interior";
            2'd2:    return "frame restart";
            default: return "flat field";
        endcase
    endfunction

    // Kernel 1-2-1 / 2-4-2 / 1-2-1 over rows r-2..r and columns c-2..c.
    function automatic rgb_t blur_at(input int r, input int c);
        logic [15:0] acc;
        logic [15:0] w;
        logic [15:0] px;
        rgb_t        res;
        for (int ch = 0; ch < 3; ch++) begin
            acc = 16'd8;
            for (int dr = 0; dr < 3; dr++) begin
                for (int dc = 0; dc < 3; dc++) begin
                    w   = ((dr == 1) ? 16'd2 : 16'd1) * ((dc == 1) ? 16'd2 : 16'd1);
                    px  = {8'd0, frame[r-2+dr][c-2+dc][ch*8 +: 8]};
                    acc = acc + w * px;
                end
            end
            res[ch*8 +: 8] = acc[11:4];
        end
        return res;
    endfunction

    task automatic report_mismatch(input string name, input logic [23:0] exp_val,
                                   input logic [23:0] act_val);
        $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp_val, act_val);
        fails[expd.test] += 1;
    endtask

    task automatic report_test(input logic [1:0] t);
        $display("Test %0d (%s): %0d cycles checked, %0d mismatches, %s",
                 t, test_name(t), checks[t], fails[t], (fails[t] == 0) ? "ok" : "failed");
    endtask

    task automatic drive_cycle(input logic hs, input logic vs, input logic d, input rgb_t px,
                               input logic [1:0] test, input rgb_t exp_px);
        @(negedge clk);
        hsync       = hs;
        vsync       = vs;
        de          = d;
        pix_in      = px;
        exp_in.sync = {hs, vs, d};
        exp_in.pix  = exp_px;
        exp_in.test = test;
    endtask

    // Vertical blank lines first, hsync in each line's blanking.
    task automatic run_frame(input logic [1:0] test, input logic flat, input rgb_t colour);
        logic [31:0] rnd;
        rgb_t        px;
        rgb_t        exp_px;
        int          row;
        logic        vblank;
        for (int line = 0; line < V_BLANK + V; line++) begin
            vblank = (line < V_BLANK);
            row    = line - V_BLANK;
            for (int x = 0; x < H + H_BLANK; x++) begin
                if (!vblank && x < H) begin
                    rnd = $urandom();
                    if (flat) begin
                        px = colour;
                    end else begin
                        px = rnd[23:0];
                    end
                    frame[row][x] = px;
                    if (row < 2 || x < 2) begin
                        exp_px = '0; // Border is black.
                    end else begin
                        exp_px = blur_at(row, x);
                    end
                    drive_cycle(1'b0, 1'b0, 1'b1, px, test, exp_px);
                end else begin
                    drive_cycle(x >= H, vblank, 1'b0, '0, test, '0);
                end
            end
        end
    endtask

    always @(negedge clk) begin
        checks[expd.test] += 1;
        if (expd.test != last_test) begin
            report_test(last_test);
            last_test = expd.test;
        end
    end

    reset_pix_chk: assert property (@(negedge clk) !in_reset || pix_out == 24'd0)
        else report_mismatch("pix_out", 24'd0, pix_out);
    reset_sync_chk: assert property (@(negedge clk)
        !in_reset || {out_hsync, out_vsync, out_de} == 3'b000)
        else report_mismatch("out_hsync,out_vsync,out_de", 24'd0,
                             {21'd0, out_hsync, out_vsync, out_de});
    hsync_chk: assert property (@(negedge clk) out_hsync == expd.sync.hsync)
        else report_mismatch("out_hsync", {23'd0, expd.sync.hsync}, {23'd0, out_hsync});
    vsync_chk: assert property (@(negedge clk) out_vsync == expd.sync.vsync)
        else report_mismatch("out_vsync", {23'd0, expd.sync.vsync}, {23'd0, out_vsync});
    de_chk: assert property (@(negedge clk) out_de == expd.sync.de)
        else report_mismatch("out_de", {23'd0, expd.sync.de}, {23'd0, out_de});
    pix_chk: assert property (@(negedge clk) pix_out == expd.pix)
        else report_mismatch("pix_out", expd.pix, pix_out);

    initial begin
        logic [31:0] rnd;
        rgb_t        colour;
        int          total_checks;
        int          total_fails;
        int          failed_tests;
        void'($urandom(SEED));
        reset  = 1'b1;
        hsync  = 1'b0;
        vsync  = 1'b0;
        de     = 1'b0;
        pix_in = '0;
        exp_in = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        run_frame(2'd1, 1'b0, '0);
        run_frame(2'd2, 1'b0, '0);   // Second frame must not see the first.
        rnd    = $urandom();
        colour = rnd[23:0];
        run_frame(2'd3, 1'b1, colour);
        repeat (LAT + 2) drive_cycle(1'b0, 1'b0, 1'b0, '0, 2'd3, '0);
        @(posedge clk);
        report_test(2'd3);
        total_checks = 0;
        total_fails  = 0;
        failed_tests = 0;
        for (int t = 0; t < 4; t++) begin
            total_checks += checks[t];
            total_fails  += fails[t];
            if (fails[t] != 0) begin
                failed_tests++;
            end
        end
        $display("Summary: 4 tests, %0d failed, %0d cycles checked, %0d mismatches",
                 failed_tests, total_checks, total_fails);
        if (total_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_video_blur

/* vlog.f */
+incdir+include
verilog/video_pkg.sv
verilog/line_ram.sv
verilog/pipe_delay.sv
verilog/three_line_buffer.sv
verilog/window_3x3.sv
verilog/gauss_blur.sv
verilog/video_blur_top.sv
bench/tb_video_blur.sv

/* Makefile */
LOG = sim.log

.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --timing --assert -f vlog.f --top-module tb_video_blur -Mdir obj_dir

run: compile
	./obj_dir/Vtb_video_blur 2>&1 | tee $(LOG)

check: run
	@grep -qx "RESULT: PASS" $(LOG) || (echo "Pass line missing in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
